// ==== verilog/axi_lite_pkg.sv ====
// AXI4-lite side types for a 32-bit data path only, with no burst, id, prot or exclusive access
package axi_lite_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8; // one enable per byte lane

  // byte address as seen on aw and ar
  typedef logic [ADDR_W-1:0] addr_t;

  // one bus word
  typedef logic [DATA_W-1:0] data_t;

  // bit n enables byte n of data_t
  typedef logic [STRB_W-1:0] strb_t;

  // response codes on b and r
  // EXOKAY and DECERR are never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00, // transfer done
    SLVERR = 2'b10  // slave error, timeout or unmapped address
  } resp_e;

endpackage

// ==== verilog/apb_pkg.sv ====
// APB side types only and psel lives outside apb_bus_t because its width follows NUM_SLAVES
package apb_pkg;

  // request from the AXI-lite front end to the APB sequencer
  // only one is ever outstanding
  typedef struct packed {
    axi_lite_pkg::addr_t addr;  // full byte address
    logic                write; // 1 for a write, 0 for a read
    axi_lite_pkg::data_t wdata; // write payload
    axi_lite_pkg::strb_t strb;  // zero on reads
  } xfer_req_t;

  // response back to the front end
  typedef struct packed {
    axi_lite_pkg::data_t rdata; // zero whenever err is set
    logic                err;   // becomes SLVERR on the AXI side
  } xfer_rsp_t;

  // outputs shared by every APB slave
  // psel stays separate as a one-hot vector
  typedef struct packed {
    axi_lite_pkg::addr_t paddr;
    logic                pwrite;
    axi_lite_pkg::data_t pwdata;
    axi_lite_pkg::strb_t pstrb;
    logic                penable; // high in the access phase only
  } apb_bus_t;

endpackage

// ==== verilog/axi_lite_front.sv ====
// one transaction at a time, reads win over writes in idle, and no response is dropped
`timescale 1ns/1ps

module axi_lite_front (
  input  logic                s_axi_clk,
  input  logic                rst_n,
  // write address
  input  axi_lite_pkg::addr_t s_axi_awaddr,
  input  logic                s_axi_awvalid,
  output logic                s_axi_awready,
  // write data
  input  axi_lite_pkg::data_t s_axi_wdata,
  input  axi_lite_pkg::strb_t s_axi_wstrb,
  input  logic                s_axi_wvalid,
  output logic                s_axi_wready,
  // write response
  output axi_lite_pkg::resp_e s_axi_bresp,
  output logic                s_axi_bvalid,
  input  logic                s_axi_bready,
  // read address
  input  axi_lite_pkg::addr_t s_axi_araddr,
  input  logic                s_axi_arvalid,
  output logic                s_axi_arready,
  // read data
  output axi_lite_pkg::data_t s_axi_rdata,
  output axi_lite_pkg::resp_e s_axi_rresp,
  output logic                s_axi_rvalid,
  input  logic                s_axi_rready,
  // towards the APB sequencer
  output apb_pkg::xfer_req_t  req,
  output logic                req_valid,
  input  apb_pkg::xfer_rsp_t  rsp,
  input  logic                rsp_valid
);

  typedef enum logic [2:0] {
    IDLE,   // accepting ar, aw, w
    ISSUE,  // req_valid pulse
    BUSY,   // waiting for rsp_valid
    B_RESP, // holding bvalid
    R_RESP  // holding rvalid
  } state_e;

  state_e state;
  state_e state_nxt;

  logic aw_held; // write address already captured
  logic w_held;  // write data already captured
  logic rd_q;    // transaction in flight is a read

  axi_lite_pkg::addr_t awaddr_q;
  axi_lite_pkg::addr_t araddr_q;
  axi_lite_pkg::data_t wdata_q;
  axi_lite_pkg::strb_t wstrb_q;
  axi_lite_pkg::data_t rdata_q;
  axi_lite_pkg::resp_e resp_q;

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic wr_go; // both write halves present after this cycle

  // ready only in idle, a pending ar blocks both write channels
  assign s_axi_arready = (state == IDLE) && s_axi_arvalid;
  assign s_axi_awready = (state == IDLE) && !aw_held && !s_axi_arvalid;
  assign s_axi_wready  = (state == IDLE) && !w_held && !s_axi_arvalid;

  assign ar_hs = s_axi_arvalid && s_axi_arready;
  assign aw_hs = s_axi_awvalid && s_axi_awready;
  assign w_hs  = s_axi_wvalid && s_axi_wready;

  assign wr_go = (state == IDLE) && !ar_hs && (aw_held || aw_hs) && (w_held || w_hs);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ar_hs || wr_go) begin
          state_nxt = ISSUE;
        end
      end
      ISSUE: begin
        state_nxt = BUSY; // req_valid lasts exactly one cycle
      end
      BUSY: begin
        if (rsp_valid) begin
          state_nxt = rd_q ? R_RESP : B_RESP;
        end
      end
      B_RESP: begin
        if (s_axi_bready) begin
          state_nxt = IDLE;
        end
      end
      R_RESP: begin
        if (s_axi_rready) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge s_axi_clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      rd_q    <= 1'b0;
    end else begin
      state <= state_nxt;
      if (ar_hs) begin
        rd_q <= 1'b1;
      end else if (wr_go) begin
        rd_q <= 1'b0;
      end
      if (wr_go) begin
        aw_held <= 1'b0; // both halves consumed by the issue
        w_held  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_held <= 1'b1;
        end
        if (w_hs) begin
          w_held <= 1'b1;
        end
      end
    end
  end

  // channel payloads, each half captured on its own handshake
  always_ff @(posedge s_axi_clk) begin
    if (aw_hs) begin
      awaddr_q <= s_axi_awaddr;
    end
    if (w_hs) begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
    if (ar_hs) begin
      araddr_q <= s_axi_araddr;
    end
    if ((state == BUSY) && rsp_valid) begin
      resp_q  <= rsp.err ? axi_lite_pkg::SLVERR : axi_lite_pkg::OKAY;
      rdata_q <= rsp.rdata;
    end
  end

  always_comb begin
    req.addr  = rd_q ? araddr_q : awaddr_q;
    req.write = !rd_q;
    req.wdata = wdata_q;
    req.strb  = rd_q ? '0 : wstrb_q; // no byte lanes on a read
  end

  assign req_valid = (state == ISSUE);

  // response held until the master takes it
  assign s_axi_bvalid = (state == B_RESP);
  assign s_axi_bresp  = resp_q;
  assign s_axi_rvalid = (state == R_RESP);
  assign s_axi_rresp  = resp_q;
  assign s_axi_rdata  = rdata_q;

  b_hold_a: assert property (@(posedge s_axi_clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

  r_hold_a: assert property (@(posedge s_axi_clk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rresp) && $stable(s_axi_rdata));

endmodule

// ==== verilog/apb_master.sv ====
// one APB transfer at a time, any error returns zero read data, TIMEOUT_CYCLES must be at least 1
`timescale 1ns/1ps

module apb_master #(
  parameter int unsigned TIMEOUT_CYCLES = 16
) (
  input  logic                s_axi_clk,
  input  logic                rst_n,
  // from the front end
  input  apb_pkg::xfer_req_t  req,
  input  logic                req_valid,
  output apb_pkg::xfer_rsp_t  rsp,
  output logic                rsp_valid,
  // shared APB outputs and decode enable
  output apb_pkg::apb_bus_t   bus,
  output logic                sel_en,
  // return path from the slave select
  input  logic                hit,
  input  logic                sel_ready,
  input  axi_lite_pkg::data_t sel_rdata,
  input  logic                sel_err
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  typedef enum logic [1:0] {
    IDLE,   // bus quiet
    SETUP,  // psel high, penable low
    ACCESS, // penable high until pready or timeout
    DONE    // rsp_valid pulse
  } phase_e;

  phase_e phase;
  phase_e phase_nxt;

  logic [CNT_W-1:0]    wait_cnt;  // access cycles so far
  logic                timed_out;
  logic                miss;      // decode found no region
  apb_pkg::xfer_req_t  req_q;
  axi_lite_pkg::data_t rdata_q;
  logic                err_q;

  // last allowed access cycle and still no pready
  assign timed_out = (phase == ACCESS) && !sel_ready &&
                     (wait_cnt == CNT_W'(TIMEOUT_CYCLES - 1));

  // decode of the latched address is first valid in setup
  assign miss = (phase == SETUP) && !hit;

  always_comb begin
    phase_nxt = phase;
    case (phase)
      IDLE: begin
        if (req_valid) begin
          phase_nxt = SETUP;
        end
      end
      SETUP: begin
        phase_nxt = hit ? ACCESS : IDLE; // unmapped answers right here
      end
      ACCESS: begin
        if (sel_ready || timed_out) begin
          phase_nxt = DONE;
        end
      end
      default: begin
        phase_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge s_axi_clk) begin
    if (!rst_n) begin
      phase    <= IDLE;
      wait_cnt <= '0;
    end else begin
      phase <= phase_nxt;
      if (phase == ACCESS) begin
        wait_cnt <= wait_cnt + CNT_W'(1);
      end else begin
        wait_cnt <= '0; // restarts for every transfer
      end
    end
  end

  always_ff @(posedge s_axi_clk) begin
    if ((phase == IDLE) && req_valid) begin
      req_q <= req;
    end
    if ((phase == ACCESS) && sel_ready) begin
      err_q   <= sel_err;
      rdata_q <= sel_err ? '0 : sel_rdata;
    end else if (timed_out) begin
      err_q   <= 1'b1; // dead slave
      rdata_q <= '0;
    end
  end

  // bus held steady from setup through access
  always_comb begin
    bus.paddr   = req_q.addr;
    bus.pwrite  = req_q.write;
    bus.pwdata  = req_q.wdata;
    bus.pstrb   = req_q.strb;
    bus.penable = (phase == ACCESS);
  end

  assign sel_en = (phase == SETUP) || (phase == ACCESS);

  assign rsp_valid = (phase == DONE) || miss;
  assign rsp.err   = miss ? 1'b1 : err_q;
  assign rsp.rdata = miss ? '0 : rdata_q;

  // access only ever runs on an address the decode still matches
  penable_a: assert property (@(posedge s_axi_clk) disable iff (!rst_n)
    bus.penable |-> sel_en && hit);

  // the front end only issues when this side is idle
  req_idle_a: assert property (@(posedge s_axi_clk) disable iff (!rst_n)
    req_valid |-> (phase == IDLE));

endmodule

// ==== verilog/apb_slave_select.sv ====
// regions are equal sized and back to back from BASE_ADDR and must stay below 2**32
`timescale 1ns/1ps

module apb_slave_select #(
  parameter int unsigned         NUM_SLAVES  = 4,
  parameter axi_lite_pkg::addr_t BASE_ADDR   = 32'h1000,
  parameter axi_lite_pkg::addr_t REGION_SIZE = 32'h100
) (
  input  axi_lite_pkg::addr_t                  paddr,
  input  logic                                 sel_en,
  output logic [NUM_SLAVES-1:0]                psel,
  output logic                                 hit,
  input  logic [NUM_SLAVES-1:0]                pready,
  input  axi_lite_pkg::data_t [NUM_SLAVES-1:0] prdata,
  input  logic [NUM_SLAVES-1:0]                pslverr,
  output logic                                 sel_ready,
  output axi_lite_pkg::data_t                  sel_rdata,
  output logic                                 sel_err
);

  localparam int DW = $bits(axi_lite_pkg::data_t);

  logic [NUM_SLAVES-1:0] hit_vec; // one-hot region match

  // 33 bit bounds so the top region end cannot wrap
  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_region
    localparam logic [32:0] LO = {1'b0, BASE_ADDR} + 33'(i) * {1'b0, REGION_SIZE};
    localparam logic [32:0] HI = LO + {1'b0, REGION_SIZE};
    assign hit_vec[i] = ({1'b0, paddr} >= LO) && ({1'b0, paddr} < HI);
  end

  assign hit  = |hit_vec;
  assign psel = hit_vec & {NUM_SLAVES{sel_en}};

  // AND-OR return mux, quiet when nothing selected
  assign sel_ready = |(pready & psel);
  assign sel_err   = |(pslverr & psel);

  always_comb begin
    sel_rdata = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel_rdata = sel_rdata | (prdata[i] & {DW{psel[i]}});
    end
  end

  // overlapping regions would break the mux
  always_comb begin
    psel_onehot_a: assert ($onehot0(psel));
  end

endmodule

// ==== verilog/axi_apb_bridge.sv ====
// single clock, one transaction in flight, unmapped addresses get SLVERR with no APB access
`timescale 1ns/1ps

module axi_apb_bridge #(
  parameter int unsigned         NUM_SLAVES     = 4,       // 1 to 16
  parameter axi_lite_pkg::addr_t BASE_ADDR      = 32'h1000,
  parameter axi_lite_pkg::addr_t REGION_SIZE    = 32'h100,
  parameter int unsigned         TIMEOUT_CYCLES = 16
) (
  input  logic                                 s_axi_clk,
  input  logic                                 rst_n,
  // AXI4-lite slave
  input  axi_lite_pkg::addr_t                  s_axi_awaddr,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  axi_lite_pkg::data_t                  s_axi_wdata,
  input  axi_lite_pkg::strb_t                  s_axi_wstrb,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output axi_lite_pkg::resp_e                  s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  input  axi_lite_pkg::addr_t                  s_axi_araddr,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output axi_lite_pkg::data_t                  s_axi_rdata,
  output axi_lite_pkg::resp_e                  s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,
  // APB master
  output axi_lite_pkg::addr_t                  m_apb_paddr,
  output logic [NUM_SLAVES-1:0]                m_apb_psel,
  output logic                                 m_apb_penable,
  output logic                                 m_apb_pwrite,
  output axi_lite_pkg::data_t                  m_apb_pwdata,
  output axi_lite_pkg::strb_t                  m_apb_pstrb,
  input  logic [NUM_SLAVES-1:0]                m_apb_pready,
  input  axi_lite_pkg::data_t [NUM_SLAVES-1:0] m_apb_prdata,
  input  logic [NUM_SLAVES-1:0]                m_apb_pslverr
);

  apb_pkg::xfer_req_t  req;
  logic                req_valid;
  apb_pkg::xfer_rsp_t  rsp;
  logic                rsp_valid;
  apb_pkg::apb_bus_t   bus;
  logic                sel_en;
  logic                hit;
  logic                sel_ready;
  axi_lite_pkg::data_t sel_rdata;
  logic                sel_err;

  axi_lite_front i_axi_lite_front (
    .s_axi_clk     (s_axi_clk),
    .rst_n         (rst_n),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .req           (req),
    .req_valid     (req_valid),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid)
  );

  apb_master #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_apb_master (
    .s_axi_clk (s_axi_clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .bus       (bus),
    .sel_en    (sel_en),
    .hit       (hit),
    .sel_ready (sel_ready),
    .sel_rdata (sel_rdata),
    .sel_err   (sel_err)
  );

  apb_slave_select #(
    .NUM_SLAVES  (NUM_SLAVES),
    .BASE_ADDR   (BASE_ADDR),
    .REGION_SIZE (REGION_SIZE)
  ) i_apb_slave_select (
    .paddr     (bus.paddr),
    .sel_en    (sel_en),
    .psel      (m_apb_psel),
    .hit       (hit),
    .pready    (m_apb_pready),
    .prdata    (m_apb_prdata),
    .pslverr   (m_apb_pslverr),
    .sel_ready (sel_ready),
    .sel_rdata (sel_rdata),
    .sel_err   (sel_err)
  );

  // shared APB outputs out of the struct
  assign m_apb_paddr   = bus.paddr;
  assign m_apb_pwrite  = bus.pwrite;
  assign m_apb_pwdata  = bus.pwdata;
  assign m_apb_pstrb   = bus.pstrb;
  assign m_apb_penable = bus.penable;

endmodule

// ==== sim/tb_apb_slave_model.sv ====
// word aligned APB slave, memory refilled on reset, last word refuses writes with pslverr
`timescale 1ns/1ps

module tb_apb_slave_model #(
  parameter int unsigned         IDX         = 0,
  parameter axi_lite_pkg::addr_t BASE_ADDR   = 32'h1000,
  parameter axi_lite_pkg::addr_t REGION_SIZE = 32'h100,
  parameter bit                  DEAD        = 1'b0 // never raises pready
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  axi_lite_pkg::addr_t paddr,
  input  axi_lite_pkg::data_t pwdata,
  input  axi_lite_pkg::strb_t pstrb,
  output logic                pready,
  output axi_lite_pkg::data_t prdata,
  output logic                pslverr
);

  localparam int unsigned         WORDS = REGION_SIZE / 4;
  localparam int                  IW    = $clog2(WORDS);
  localparam axi_lite_pkg::addr_t LO    = BASE_ADDR + IDX * REGION_SIZE;

  axi_lite_pkg::data_t mem [WORDS];
  logic [31:0]         rng;       // own xorshift state
  logic [2:0]          wait_n;    // wait states for this transfer
  logic [2:0]          wait_cnt;
  logic [31:0]         word_idx;
  logic                last_word;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // pattern over the whole byte address
  function automatic axi_lite_pkg::data_t fill_word(input axi_lite_pkg::addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
  endfunction

  assign word_idx  = (paddr - LO) >> 2;
  assign last_word = (word_idx == 32'(WORDS - 1));
  assign pready    = psel && penable && !DEAD && (wait_cnt == wait_n);
  assign prdata    = psel ? mem[word_idx[IW-1:0]] : '0;
  assign pslverr   = pready && pwrite && last_word; // reads of it stay fine

  always @(posedge clk) begin
    if (!rst_n) begin
      rng      <= 32'h829f + IDX; // distinct stream per slave
      wait_n   <= '0;
      wait_cnt <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= fill_word(LO + 32'(i) * 4);
      end
    end else begin
      if (psel && !penable) begin // setup picks 0 to 5 waits
        rng      <= xorshift(rng);
        wait_n   <= 3'(xorshift(rng) % 6);
        wait_cnt <= '0;
      end else if (psel && penable && !pready) begin
        wait_cnt <= wait_cnt + 3'd1;
      end
      if (pready && pwrite && !last_word) begin
        for (int b = 0; b < 4; b++) begin
          if (pstrb[b]) begin
            mem[word_idx[IW-1:0]][8*b +: 8] <= pwdata[8*b +: 8]; // byte merge
          end
        end
      end
    end
  end

endmodule

// ==== sim/tb_axi_apb_bridge.sv ====
// 4 slaves on the default map with slave 3 dead and word aligned random traffic from a fixed seed
`timescale 1ns/1ps

module tb_axi_apb_bridge;

  localparam int unsigned         NUM_SLAVES  = 4;
  localparam axi_lite_pkg::addr_t BASE_ADDR   = 32'h1000;
  localparam axi_lite_pkg::addr_t REGION_SIZE = 32'h100;
  localparam int                  WORDS       = 64;
  localparam int                  DEAD_SLAVE  = 3;
  localparam int                  NUM_TXN     = 300;
  localparam int                  WAIT_LIMIT  = 100; // cycles per wait loop
  localparam logic [31:0]         RESP_SLVERR = 32'd2;

  logic s_axi_clk;
  logic rst_n;
  axi_lite_pkg::addr_t s_axi_awaddr;
  logic s_axi_awvalid;
  logic s_axi_awready;
  axi_lite_pkg::data_t s_axi_wdata;
  axi_lite_pkg::strb_t s_axi_wstrb;
  logic s_axi_wvalid;
  logic s_axi_wready;
  axi_lite_pkg::resp_e s_axi_bresp;
  logic s_axi_bvalid;
  logic s_axi_bready;
  axi_lite_pkg::addr_t s_axi_araddr;
  logic s_axi_arvalid;
  logic s_axi_arready;
  axi_lite_pkg::data_t s_axi_rdata;
  axi_lite_pkg::resp_e s_axi_rresp;
  logic s_axi_rvalid;
  logic s_axi_rready;
  axi_lite_pkg::addr_t m_apb_paddr;
  logic [NUM_SLAVES-1:0] m_apb_psel;
  logic m_apb_penable;
  logic m_apb_pwrite;
  axi_lite_pkg::data_t m_apb_pwdata;
  axi_lite_pkg::strb_t m_apb_pstrb;
  logic [NUM_SLAVES-1:0] m_apb_pready;
  axi_lite_pkg::data_t [NUM_SLAVES-1:0] m_apb_prdata;
  logic [NUM_SLAVES-1:0] m_apb_pslverr;

  logic [31:0]         rng;
  int                  errors;
  int                  checks;
  bit                  hang; // some wait loop ran out
  axi_lite_pkg::data_t model_mem [NUM_SLAVES][WORDS];

  axi_apb_bridge #(
    .NUM_SLAVES     (NUM_SLAVES),
    .BASE_ADDR      (BASE_ADDR),
    .REGION_SIZE    (REGION_SIZE),
    .TIMEOUT_CYCLES (16)
  ) i_axi_apb_bridge (
    .s_axi_clk, .rst_n,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
    .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
    .m_apb_paddr, .m_apb_psel, .m_apb_penable, .m_apb_pwrite, .m_apb_pwdata,
    .m_apb_pstrb, .m_apb_pready, .m_apb_prdata, .m_apb_pslverr
  );

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
    tb_apb_slave_model #(
      .IDX         (i),
      .BASE_ADDR   (BASE_ADDR),
      .REGION_SIZE (REGION_SIZE),
      .DEAD        (i == DEAD_SLAVE)
    ) i_slave (
      .clk     (s_axi_clk),
      .rst_n   (rst_n),
      .psel    (m_apb_psel[i]),
      .penable (m_apb_penable),
      .pwrite  (m_apb_pwrite),
      .paddr   (m_apb_paddr),
      .pwdata  (m_apb_pwdata),
      .pstrb   (m_apb_pstrb),
      .pready  (m_apb_pready[i]),
      .prdata  (m_apb_prdata[i]),
      .pslverr (m_apb_pslverr[i])
    );
  end

  always #5 s_axi_clk = ~s_axi_clk; // 10 ns period

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // same fill rule as the slave models
  function automatic axi_lite_pkg::data_t fill_word(input axi_lite_pkg::addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
  endfunction

  // slave index from the map rule or -1 when unmapped
  function automatic int region_of(input axi_lite_pkg::addr_t a);
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (a >= BASE_ADDR + REGION_SIZE * 32'(i) && a < BASE_ADDR + REGION_SIZE * 32'(i + 1)) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic [NUM_SLAVES-1:0] decode_onehot(input axi_lite_pkg::addr_t a);
    logic [NUM_SLAVES-1:0] d;
    int                    s;
    d = '0;
    s = region_of(a);
    if (s >= 0) begin
      d[s] = 1'b1;
    end
    return d;
  endfunction

  // mostly words 0 to 7 so reads meet earlier writes
  function automatic axi_lite_pkg::addr_t pick_addr();
    logic [31:0] r;
    logic [31:0] slave;
    r     = next_random();
    slave = (r[10:9] == 2'd3) ? 32'd0 : {30'd0, r[10:9]};
    case (r[2:0])
      3'd0: return r[12] ? {20'd0, r[11:2], 2'b00} : 32'h1400 + {20'd0, r[11:2], 2'b00};
      3'd1: return BASE_ADDR + REGION_SIZE * 32'(DEAD_SLAVE) + {27'd0, r[5:3], 2'b00};
      3'd2: return BASE_ADDR + REGION_SIZE * slave + REGION_SIZE - 32'd4; // last word
      default: return BASE_ADDR + REGION_SIZE * slave + {27'd0, r[5:3], 2'b00};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // any live select must match the decode of paddr and carry the transfer in flight
  task automatic compare_apb_bus(input axi_lite_pkg::addr_t addr, input logic write,
                                 input axi_lite_pkg::data_t wdata,
                                 input axi_lite_pkg::strb_t strb);
    if (m_apb_psel != '0) begin
      check_value("m_apb_psel", 32'(m_apb_psel), 32'(decode_onehot(m_apb_paddr)));
      check_value("m_apb_paddr", m_apb_paddr, addr);
      check_value("m_apb_pwrite", 32'(m_apb_pwrite), 32'(write));
      check_value("m_apb_pstrb", 32'(m_apb_pstrb), write ? 32'(strb) : 32'd0); // none on reads
      if (write) begin
        check_value("m_apb_pwdata", m_apb_pwdata, wdata);
      end
    end
  endtask

  // reference model that updates model_mem on a good write
  task automatic predict(input axi_lite_pkg::addr_t addr, input logic write,
                         input axi_lite_pkg::data_t wdata, input axi_lite_pkg::strb_t strb,
                         output logic err, output axi_lite_pkg::data_t rdata);
    int s;
    int w;
    s     = region_of(addr);
    err   = 1'b1; // unmapped or dead slave
    rdata = '0;
    if (s >= 0 && s != DEAD_SLAVE) begin
      w = int'((addr - BASE_ADDR - REGION_SIZE * 32'(s)) >> 2);
      if (!write) begin
        err   = 1'b0;
        rdata = model_mem[s][w];
      end else if (w != WORDS - 1) begin
        err = 1'b0;
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            model_mem[s][w][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
    end
  endtask

  task automatic write_txn(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                           input axi_lite_pkg::strb_t strb);
    logic                exp_err;
    axi_lite_pkg::data_t exp_rdata;
    logic [31:0]         rnd;
    int                  aw_wait;
    int                  w_wait;
    int                  n;
    bit                  aw_done;
    bit                  w_done;
    bit                  seen;
    bit                  done;
    predict(addr, 1'b1, data, strb, exp_err, exp_rdata);
    rnd     = next_random();
    aw_wait = int'(rnd % 4); // random gaps give either order
    w_wait  = int'((rnd >> 8) % 4);
    aw_done = 1'b0;
    w_done  = 1'b0;
    n       = 0;
    while (!(aw_done && w_done)) begin
      @(negedge s_axi_clk);
      s_axi_bready  = 1'b0;
      s_axi_awaddr  = addr;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_awvalid = !aw_done && (n >= aw_wait);
      s_axi_wvalid  = !w_done && (n >= w_wait);
      #1; // readies settled until the next edge
      compare_apb_bus(addr, 1'b1, data, strb);
      aw_done = aw_done || (s_axi_awvalid && s_axi_awready);
      w_done  = w_done || (s_axi_wvalid && s_axi_wready);
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: write address or data never accepted at %0t", $time);
        errors++;
        hang = 1'b1;
        return;
      end
    end
    n    = 0;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge s_axi_clk);
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      rnd           = next_random();
      s_axi_bready  = rnd[0];
      #1;
      compare_apb_bus(addr, 1'b1, data, strb);
      if (seen && !s_axi_bvalid) begin
        check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd1); // dropped before bready
      end
      if (s_axi_bvalid) begin
        seen = 1'b1;
        check_value("s_axi_bresp", 32'(s_axi_bresp), exp_err ? RESP_SLVERR : 32'd0);
        done = s_axi_bready;
      end
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: no write response at %0t", $time);
        errors++;
        hang = 1'b1;
        return;
      end
    end
  endtask

  task automatic read_txn(input axi_lite_pkg::addr_t addr);
    logic                exp_err;
    axi_lite_pkg::data_t exp_rdata;
    logic [31:0]         rnd;
    int                  ar_wait;
    int                  n;
    bit                  seen;
    bit                  done;
    predict(addr, 1'b0, '0, '0, exp_err, exp_rdata);
    rnd     = next_random();
    ar_wait = int'(rnd % 4);
    n       = 0;
    done    = 1'b0;
    while (!done) begin
      @(negedge s_axi_clk);
      s_axi_bready  = 1'b0;
      s_axi_rready  = 1'b0;
      s_axi_araddr  = addr;
      s_axi_arvalid = (n >= ar_wait);
      #1;
      compare_apb_bus(addr, 1'b0, '0, '0);
      done = s_axi_arvalid && s_axi_arready;
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: read address never accepted at %0t", $time);
        errors++;
        hang = 1'b1;
        return;
      end
    end
    n    = 0;
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge s_axi_clk);
      s_axi_arvalid = 1'b0;
      rnd           = next_random();
      s_axi_rready  = rnd[0];
      #1;
      compare_apb_bus(addr, 1'b0, '0, '0);
      if (seen && !s_axi_rvalid) begin
        check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd1);
      end
      if (s_axi_rvalid) begin
        seen = 1'b1;
        check_value("s_axi_rresp", 32'(s_axi_rresp), exp_err ? RESP_SLVERR : 32'd0);
        check_value("s_axi_rdata", s_axi_rdata, exp_rdata); // zero on any error
        done = s_axi_rready;
      end
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: no read response at %0t", $time);
        errors++;
        hang = 1'b1;
        return;
      end
    end
  endtask

  initial begin : main
    logic [31:0]         rnd;
    axi_lite_pkg::addr_t addr;
    s_axi_clk     = 1'b0;
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    rng           = 32'h829f;
    errors        = 0;
    checks        = 0;
    hang          = 1'b0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        model_mem[s][w] = fill_word(BASE_ADDR + REGION_SIZE * 32'(s) + 32'(w) * 4);
      end
    end
    repeat (5) @(posedge s_axi_clk); // reset for 5 cycles
    @(negedge s_axi_clk);
    rst_n = 1'b1;
    #1;
    // idle after reset with only the write side open
    check_value("s_axi_arready", 32'(s_axi_arready), 32'd0);
    check_value("s_axi_awready", 32'(s_axi_awready), 32'd1);
    check_value("s_axi_wready", 32'(s_axi_wready), 32'd1);
    check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
    check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
    check_value("m_apb_psel", 32'(m_apb_psel), 32'd0);
    check_value("m_apb_penable", 32'(m_apb_penable), 32'd0);
    for (int t = 0; t < NUM_TXN && !hang; t++) begin
      rnd  = next_random();
      addr = pick_addr();
      if (rnd[0]) begin
        write_txn(addr, next_random(), rnd[7:4]);
        if (rnd[1] && !hang) begin
          read_txn(addr); // read back the same word
        end
      end else begin
        read_txn(addr);
      end
    end
    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
verilog/axi_lite_pkg.sv
verilog/apb_pkg.sv
verilog/axi_lite_front.sv
verilog/apb_master.sv
verilog/apb_slave_select.sv
verilog/axi_apb_bridge.sv
sim/tb_apb_slave_model.sv
sim/tb_axi_apb_bridge.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and decides on the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module tb_axi_apb_bridge -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
